// ==== common/mcd_params.svh ====
`ifndef MCD_PARAMS_SVH
`define MCD_PARAMS_SVH

// Plane count and bus widths
`define MCD_NUM_PLANES 2
`define MCD_REG_ADR_W 7
`define MCD_REG_DATA_W 24
`define MCD_PIX_W 8
`define MCD_COLOR_W 6

// Per-plane colour table, two banks of 64 entries
`define MCD_CLUT_DEPTH 128
`define MCD_CLUT_ADR_W 7

// Register map, channel 0 and channel 1 share the CLUT and bank addresses
`define MCD_REG_CLUT_LAST 7'h3F
`define MCD_REG_ORDER 7'h42
`define MCD_REG_BANK 7'h43
`define MCD_REG_TRANS_A 7'h44
`define MCD_REG_TRANS_B 7'h46
`define MCD_REG_BACKDROP 7'h58
`define MCD_REG_WEIGHT_A 7'h5B
`define MCD_REG_WEIGHT_B 7'h5C

`endif

// ==== common/mcd_pkg.sv ====
`include "mcd_params.svh"

package mcd_pkg;

    typedef struct packed {
        logic [`MCD_COLOR_W-1:0] r;
        logic [`MCD_COLOR_W-1:0] g;
        logic [`MCD_COLOR_W-1:0] b;
    } clut_entry_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Colour registers carry 6 bits per channel, left aligned in each byte
    typedef struct packed {
        logic [`MCD_COLOR_W-1:0] r;
        logic [1:0] r_low;
        logic [`MCD_COLOR_W-1:0] g;
        logic [1:0] g_low;
        logic [`MCD_COLOR_W-1:0] b;
        logic [1:0] b_low;
    } reg_color_t;

    // Bank, weight, backdrop and order all sit in the low 6 bits
    typedef struct packed {
        logic [`MCD_REG_DATA_W-7:0] upper;
        logic [5:0] field;
    } reg_ctrl_t;

    typedef union packed {
        reg_color_t color;
        reg_ctrl_t ctrl;
    } reg_data_u;

    typedef struct packed {
        logic strobe;
        logic [`MCD_REG_ADR_W-1:0] adr;
        reg_data_u data;
    } reg_write_t;

    typedef struct packed {
        logic clut_we;
        logic [`MCD_CLUT_ADR_W-2:0] clut_adr;
        logic bank_we;
        logic trans_we;
        logic weight_we;
        reg_data_u data;
    } plane_cmd_t;

    typedef struct packed {
        logic valid;
        logic [`MCD_NUM_PLANES-1:0][`MCD_PIX_W-1:0] code;
    } pixel_in_t;

    typedef struct packed {
        logic valid;
        logic visible;
        rgb888_t rgb;
    } plane_out_t;

    typedef struct packed {
        logic y;
        logic r;
        logic g;
        logic b;
    } backdrop_t;

    typedef struct packed {
        backdrop_t backdrop;
        logic b_in_front;
    } mixer_cfg_t;

endpackage

// ==== plane/clut_ram.sv ====
`timescale 1ns/10ps
`include "mcd_params.svh"

module clut_ram
    import mcd_pkg::*;
(
    input  logic                       clk,
    input  logic                       we,
    input  logic [`MCD_CLUT_ADR_W-1:0] addr,
    input  clut_entry_t                wdata,
    output clut_entry_t                rdata
);

    clut_entry_t mem [`MCD_CLUT_DEPTH];

    // Write-first, a write returns the new entry on the same edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== plane/clut_plane.sv ====
`timescale 1ns/10ps
`include "mcd_params.svh"

module clut_plane
    import mcd_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  plane_cmd_t            cmd,
    input  logic                  pix_valid,
    input  logic [`MCD_PIX_W-1:0] pix_code,
    output plane_out_t            out
);

    logic bank;
    clut_entry_t trans_color;
    logic [5:0] weight;

    clut_entry_t wr_entry;
    logic [`MCD_CLUT_ADR_W-1:0] ram_addr;
    clut_entry_t clut_data;
    logic valid_s1;

    // Entry value times (weight + 1) / 64, on the 8-bit scale
    function automatic logic [7:0] scale(
        input logic [`MCD_COLOR_W-1:0] c,
        input logic [5:0] w
    );
        logic [13:0] prod;
        prod = 14'({c, 2'b00}) * (14'(w) + 14'd1);
        return prod[13:6];
    endfunction

    assign wr_entry = '{
        r: cmd.data.color.r,
        g: cmd.data.color.g,
        b: cmd.data.color.b
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            bank <= 1'b0;
            trans_color <= '0;
            weight <= '0;
        end else begin
            if (cmd.bank_we) begin
                bank <= cmd.data.ctrl.field[0];
            end
            if (cmd.trans_we) begin
                trans_color <= wr_entry;
            end
            if (cmd.weight_we) begin
                weight <= cmd.data.ctrl.field;
            end
        end
    end

    // Writes borrow the single RAM port, code bit 7 is ignored
    assign ram_addr = cmd.clut_we ? {bank, cmd.clut_adr} : pix_code[`MCD_CLUT_ADR_W-1:0];

    clut_ram ram_i (
        .clk,
        .we(cmd.clut_we),
        .addr(ram_addr),
        .wdata(wr_entry),
        .rdata(clut_data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            valid_s1 <= pix_valid;
            out.valid <= valid_s1;
        end
    end

    // Transparency compares the raw entry, before weighting
    always_ff @(posedge clk) begin
        out.visible <= (clut_data != trans_color);
        out.rgb.r <= scale(clut_data.r, weight);
        out.rgb.g <= scale(clut_data.g, weight);
        out.rgb.b <= scale(clut_data.b, weight);
    end

    // A table write would steal the read port from a live pixel
    no_clut_write_on_pixel: assert property (
        @(posedge clk) disable iff (reset)
        !(cmd.clut_we && pix_valid)
    );

endmodule

// ==== hw/channel_reg_decode.sv ====
`timescale 1ns/10ps
`include "mcd_params.svh"

module channel_reg_decode
    import mcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_write_t ch0_write,
    input  reg_write_t ch1_write,
    output plane_cmd_t plane_cmd [`MCD_NUM_PLANES],
    output mixer_cfg_t mixer_cfg
);

    // Map one channel write onto the address-independent plane command
    function automatic plane_cmd_t decode_write(
        input reg_write_t wr,
        input logic [`MCD_REG_ADR_W-1:0] trans_adr,
        input logic [`MCD_REG_ADR_W-1:0] weight_adr
    );
        plane_cmd_t cmd;
        cmd.clut_we = wr.strobe && (wr.adr <= `MCD_REG_CLUT_LAST);
        cmd.clut_adr = wr.adr[`MCD_CLUT_ADR_W-2:0];
        cmd.bank_we = wr.strobe && (wr.adr == `MCD_REG_BANK);
        cmd.trans_we = wr.strobe && (wr.adr == trans_adr);
        cmd.weight_we = wr.strobe && (wr.adr == weight_adr);
        cmd.data = wr.data;
        return cmd;
    endfunction

    // Channel 0 drives plane A, channel 1 drives plane B
    always_comb begin
        plane_cmd[0] = decode_write(ch0_write, `MCD_REG_TRANS_A, `MCD_REG_WEIGHT_A);
        plane_cmd[1] = decode_write(ch1_write, `MCD_REG_TRANS_B, `MCD_REG_WEIGHT_B);
    end

    // Backdrop and plane order belong to channel 0 only
    always_ff @(posedge clk) begin
        if (reset) begin
            mixer_cfg <= '0;
        end else if (ch0_write.strobe) begin
            if (ch0_write.adr == `MCD_REG_BACKDROP) begin
                mixer_cfg.backdrop <= backdrop_t'(ch0_write.data.ctrl.field[3:0]);
            end
            if (ch0_write.adr == `MCD_REG_ORDER) begin
                mixer_cfg.b_in_front <= ch0_write.data.ctrl.field[0];
            end
        end
    end

    // Second channel is limited to the upper banks
    ch1_upper_bank_only: assert property (
        @(posedge clk) disable iff (reset)
        plane_cmd[1].bank_we |-> plane_cmd[1].data.ctrl.field[1]
    );

endmodule

// ==== hw/plane_mixer.sv ====
`timescale 1ns/10ps

module plane_mixer
    import mcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  plane_out_t plane_a,
    input  plane_out_t plane_b,
    input  mixer_cfg_t cfg,
    output rgb888_t    rgb,
    output logic       rgb_valid
);

    rgb888_t backdrop_rgb;
    rgb888_t mix_rgb;
    plane_out_t front;
    plane_out_t rear;

    always_comb begin
        backdrop_rgb.r = cfg.backdrop.r ? 8'hFF : 8'h00;
        backdrop_rgb.g = cfg.backdrop.g ? 8'hFF : 8'h00;
        backdrop_rgb.b = cfg.backdrop.b ? 8'hFF : 8'h00;
        // Half brightness when y is clear
        if (!cfg.backdrop.y) begin
            backdrop_rgb.r[7] = 1'b0;
            backdrop_rgb.g[7] = 1'b0;
            backdrop_rgb.b[7] = 1'b0;
        end
    end

    assign front = cfg.b_in_front ? plane_b : plane_a;
    assign rear = cfg.b_in_front ? plane_a : plane_b;

    always_comb begin
        mix_rgb = backdrop_rgb;
        if (rear.visible) begin
            mix_rgb = rear.rgb;
        end
        if (front.visible) begin
            mix_rgb = front.rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= plane_a.valid;
        end
    end

    // Colour holds until the next pixel arrives
    always_ff @(posedge clk) begin
        if (plane_a.valid) begin
            rgb <= mix_rgb;
        end
    end

    // Both plane pipelines see the same pixel strobe and latency
    planes_in_step: assert property (
        @(posedge clk) disable iff (reset)
        plane_a.valid == plane_b.valid
    );

endmodule

// ==== hw/mcd_video_out.sv ====
`timescale 1ns/10ps
`include "mcd_params.svh"

module mcd_video_out
    import mcd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_write_t ch0_write,
    input  reg_write_t ch1_write,
    input  pixel_in_t  pixel_in,
    output rgb888_t    rgb,
    output logic       rgb_valid
);

    plane_cmd_t plane_cmd [`MCD_NUM_PLANES];
    plane_out_t plane_out [`MCD_NUM_PLANES];
    mixer_cfg_t mixer_cfg;

    channel_reg_decode decode_i (
        .clk,
        .reset,
        .ch0_write,
        .ch1_write,
        .plane_cmd,
        .mixer_cfg
    );

    // Plane 0 is plane A, plane 1 is plane B
    generate
        for (genvar i = 0; i < `MCD_NUM_PLANES; i++) begin : g_plane
            clut_plane plane_i (
                .clk,
                .reset,
                .cmd(plane_cmd[i]),
                .pix_valid(pixel_in.valid),
                .pix_code(pixel_in.code[i]),
                .out(plane_out[i])
            );
        end
    endgenerate

    plane_mixer mixer_i (
        .clk,
        .reset,
        .plane_a(plane_out[0]),
        .plane_b(plane_out[1]),
        .cfg(mixer_cfg),
        .rgb,
        .rgb_valid
    );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Released on a rising edge to suit the synchronous reset
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== test/tb_mcd_video_out.sv ====
`timescale 1ns/10ps
`include "mcd_params.svh"

module tb_mcd_video_out
    import mcd_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int NUM_PHASES = 6;
    localparam int PHASE_CYCLES = 300;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES;
    localparam int LATENCY = 3;
    localparam int PIXELS = 64;

    logic clk;
    logic reset;
    reg_write_t ch0_write;
    reg_write_t ch1_write;
    pixel_in_t pixel_in;
    rgb888_t rgb;
    logic rgb_valid;

    // Reference model state
    clut_entry_t clut_m [`MCD_NUM_PLANES][`MCD_CLUT_DEPTH];
    logic bank_m [`MCD_NUM_PLANES];
    logic [5:0] weight_m [`MCD_NUM_PLANES];
    clut_entry_t trans_m [`MCD_NUM_PLANES];
    logic [3:0] backdrop_m;
    logic b_front_m;

    rgb888_t exp_rgb_q [$];
    int unsigned exp_edge_q [$];
    int unsigned cycle = 0;
    int unsigned checks = 0;
    int unsigned value_errors = 0;
    int unsigned protocol_errors = 0;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_i (.clk, .reset);

    mcd_video_out dut_i (
        .clk,
        .reset,
        .ch0_write,
        .ch1_write,
        .pixel_in,
        .rgb,
        .rgb_valid
    );

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at cycle %0d",
                     name, got, expected, cycle);
        end
    endtask

    task automatic report_and_finish(input logic timed_out);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, protocol_errors);
        if (timed_out || value_errors != 0 || protocol_errors != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    endtask

    // Low two bits of each byte are don't-care in a colour register
    function automatic logic [23:0] color_word(input clut_entry_t e);
        return {e.r, 2'b01, e.g, 2'b10, e.b, 2'b11};
    endfunction

    function automatic reg_write_t make_write(input logic [6:0] adr, input logic [23:0] data);
        reg_write_t w;
        w.strobe = 1'b1;
        w.adr = adr;
        w.data = data;
        return w;
    endfunction

    function automatic logic [7:0] rand_code(input logic half);
        return {1'($urandom), half, 6'($urandom)};
    endfunction

    function automatic logic [7:0] pick_code(input logic [5:0] special);
        return ($urandom % 2 == 0) ? {1'($urandom), 1'b0, special} : rand_code(1'b0);
    endfunction

    function automatic logic [7:0] weighted(input logic [5:0] c, input logic [5:0] w);
        int v;
        v = (int'(c) * 4 * (int'(w) + 1)) / 64;
        return 8'(v);
    endfunction

    function automatic logic [7:0] backdrop_level(input logic on);
        if (!on) begin
            return 8'h00;
        end
        return backdrop_m[3] ? 8'hFF : 8'h7F;
    endfunction

    function automatic rgb888_t expected_rgb(input logic [7:0] code_a, input logic [7:0] code_b);
        clut_entry_t e [2];
        logic vis [2];
        rgb888_t col [2];
        rgb888_t res;
        int front;
        e[0] = clut_m[0][code_a[6:0]];
        e[1] = clut_m[1][code_b[6:0]];
        for (int p = 0; p < 2; p++) begin
            vis[p] = (e[p] != trans_m[p]);
            col[p].r = weighted(e[p].r, weight_m[p]);
            col[p].g = weighted(e[p].g, weight_m[p]);
            col[p].b = weighted(e[p].b, weight_m[p]);
        end
        res.r = backdrop_level(backdrop_m[2]);
        res.g = backdrop_level(backdrop_m[1]);
        res.b = backdrop_level(backdrop_m[0]);
        front = b_front_m ? 1 : 0;
        if (vis[1 - front]) begin
            res = col[1 - front];
        end
        if (vis[front]) begin
            res = col[front];
        end
        return res;
    endfunction

    // Channel 0 owns plane A and the mixer registers, channel 1 owns plane B
    task automatic model_write(input int ch, input logic [6:0] adr, input logic [23:0] data);
        clut_entry_t c;
        c = {data[23:18], data[15:10], data[7:2]};
        if (adr <= `MCD_REG_CLUT_LAST) begin
            clut_m[ch][{bank_m[ch], adr[5:0]}] = c;
        end else if (adr == `MCD_REG_BANK) begin
            bank_m[ch] = data[0];
        end else if ((ch == 0 && adr == `MCD_REG_TRANS_A) || (ch == 1 && adr == `MCD_REG_TRANS_B)) begin
            trans_m[ch] = c;
        end else if ((ch == 0 && adr == `MCD_REG_WEIGHT_A) || (ch == 1 && adr == `MCD_REG_WEIGHT_B)) begin
            weight_m[ch] = data[5:0];
        end else if (ch == 0 && adr == `MCD_REG_BACKDROP) begin
            backdrop_m = data[3:0];
        end else if (ch == 0 && adr == `MCD_REG_ORDER) begin
            b_front_m = data[0];
        end
    endtask

    task automatic write_pair(input reg_write_t w0, input reg_write_t w1);
        @(posedge clk);
        ch0_write <= w0;
        ch1_write <= w1;
        pixel_in <= '0;
        if (w0.strobe) begin
            model_write(0, w0.adr, w0.data);
        end
        if (w1.strobe) begin
            model_write(1, w1.adr, w1.data);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            ch0_write <= '0;
            ch1_write <= '0;
            pixel_in <= '0;
        end
    endtask

    // Fills the half of each table picked by the current bank
    task automatic fill_cluts();
        clut_entry_t ea;
        clut_entry_t eb;
        for (int a = 0; a < 64; a++) begin
            ea = 18'($urandom);
            eb = 18'($urandom);
            write_pair(make_write(7'(a), color_word(ea)), make_write(7'(a), color_word(eb)));
        end
    endtask

    task automatic send_pixel(input logic [7:0] code_a, input logic [7:0] code_b);
        pixel_in_t p;
        if ($urandom % 4 == 0) begin
            idle(1);
        end
        p.valid = 1'b1;
        p.code[0] = code_a;
        p.code[1] = code_b;
        @(posedge clk);
        ch0_write <= '0;
        ch1_write <= '0;
        pixel_in <= p;
        exp_rgb_q.push_back(expected_rgb(code_a, code_b));
        exp_edge_q.push_back(cycle + 1);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle);
            report_and_finish(1'b1);
        end
    end

    // Outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        rgb888_t exp_rgb;
        int unsigned exp_edge;
        if (!reset) begin
            if (exp_edge_q.size() > 0 && cycle > exp_edge_q[0] + LATENCY) begin
                protocol_errors++;
                $display("No rgb_valid for the pixel driven at cycle %0d", exp_edge_q[0]);
                exp_rgb = exp_rgb_q.pop_front();
                exp_edge = exp_edge_q.pop_front();
            end
            if (rgb_valid === 1'b1) begin
                if (exp_rgb_q.size() == 0) begin
                    protocol_errors++;
                    $display("rgb_valid high at cycle %0d with no pixel pending", cycle);
                end else begin
                    exp_rgb = exp_rgb_q.pop_front();
                    exp_edge = exp_edge_q.pop_front();
                    if (cycle != exp_edge + LATENCY) begin
                        protocol_errors++;
                        $display("rgb_valid came at cycle %0d for a pixel driven at cycle %0d",
                                 cycle, exp_edge);
                    end
                    check_value("rgb.r", rgb.r, exp_rgb.r);
                    check_value("rgb.g", rgb.g, exp_rgb.g);
                    check_value("rgb.b", rgb.b, exp_rgb.b);
                end
            end
        end
    end

    initial begin
        logic [5:0] ta;
        logic [5:0] tb;
        ch0_write = '0;
        ch1_write = '0;
        pixel_in = '0;
        for (int p = 0; p < `MCD_NUM_PLANES; p++) begin
            bank_m[p] = 1'b0;
            weight_m[p] = '0;
            trans_m[p] = '0;
        end
        backdrop_m = '0;
        b_front_m = 1'b0;
        void'($urandom(17));
        while (reset !== 1'b0) begin
            @(posedge clk);
        end

        // Full weight gives the entry padded with two zero bits
        fill_cluts();
        write_pair(make_write(`MCD_REG_WEIGHT_A, 24'd63), make_write(`MCD_REG_WEIGHT_B, 24'd63));
        write_pair(make_write(`MCD_REG_BACKDROP, 24'($urandom % 16)), '0);
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(rand_code(1'b0), rand_code(1'b0));
        end
        idle(4);

        // Random weights
        write_pair(make_write(`MCD_REG_WEIGHT_A, 24'(6'($urandom))),
                   make_write(`MCD_REG_WEIGHT_B, 24'(6'($urandom))));
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(rand_code(1'b0), rand_code(1'b0));
        end
        idle(4);

        // Transparent colour taken from a used entry
        ta = 6'($urandom);
        tb = 6'($urandom);
        write_pair(make_write(`MCD_REG_TRANS_A, color_word(clut_m[0][{1'b0, ta}])),
                   make_write(`MCD_REG_TRANS_B, color_word(clut_m[1][{1'b0, tb}])));
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(pick_code(ta), pick_code(tb));
        end
        idle(4);

        // Plane order toggled twice
        for (int k = 0; k < 2; k++) begin
            write_pair(make_write(`MCD_REG_ORDER, {23'd0, ~b_front_m}), '0);
            for (int i = 0; i < PIXELS / 2; i++) begin
                send_pixel(rand_code(1'b0), rand_code(1'b0));
            end
            idle(4);
        end

        // Every backdrop value with both planes transparent
        for (int k = 0; k < 16; k++) begin
            write_pair(make_write(`MCD_REG_BACKDROP, 24'(k)), '0);
            for (int i = 0; i < 6; i++) begin
                send_pixel({1'($urandom), 1'b0, ta}, {1'($urandom), 1'b0, tb});
            end
            idle(4);
        end

        // Upper bank fill, then reads from both halves
        write_pair(make_write(`MCD_REG_BANK, 24'h3), make_write(`MCD_REG_BANK, 24'h3));
        fill_cluts();
        write_pair(make_write(`MCD_REG_WEIGHT_A, 24'(6'($urandom))),
                   make_write(`MCD_REG_WEIGHT_B, 24'(6'($urandom))));
        for (int i = 0; i < PIXELS; i++) begin
            send_pixel(rand_code(1'($urandom)), rand_code(1'($urandom)));
        end
        idle(4);

        if (exp_rgb_q.size() != 0) begin
            protocol_errors++;
            $display("%0d pixels never produced an output", exp_rgb_q.size());
        end
        report_and_finish(1'b0);
    end

endmodule

// ==== tb.f ====
+incdir+common
common/mcd_pkg.sv
plane/clut_ram.sv
plane/clut_plane.sv
hw/channel_reg_decode.sv
hw/plane_mixer.sv
hw/mcd_video_out.sv
test/tb_clock_gen.sv
test/tb_mcd_video_out.sv

// ==== Makefile ====
TOP := tb_mcd_video_out
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
